// File: hw/icache_defines.svh
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

//////////////////////////////////////////////////
// Instruction cache geometry
//////////////////////////////////////////////////

// Fetch byte address width
`define ICACHE_ADDR_W 32

// Sets in each of the two ways
`define ICACHE_SETS 16

// 32-bit words per cache line
`define ICACHE_WORDS_PER_LINE 4

// Fully associative victim slots
`define ICACHE_VICTIM_ENTRIES 4

`endif

// File: hw/icache_pkg.sv
`default_nettype none

`include "icache_defines.svh"

package icache_pkg;

    // Address split into tag, index and byte offset
    localparam int offset_w = $clog2(`ICACHE_WORDS_PER_LINE * 4);
    localparam int index_w = $clog2(`ICACHE_SETS);
    localparam int tag_w = `ICACHE_ADDR_W - index_w - offset_w;
    localparam int block_addr_w = tag_w + index_w;

    // Way or slot number; the value ICACHE_VICTIM_ENTRIES means insert
    localparam int slot_w = $clog2(`ICACHE_VICTIM_ENTRIES + 1);

    typedef logic [31:0] word_t;
    typedef word_t [`ICACHE_WORDS_PER_LINE-1:0] line_t;
    typedef logic [block_addr_w-1:0] block_addr_t;
    typedef logic [slot_w-1:0] slot_t;

    typedef struct packed {
        logic valid;
        logic [`ICACHE_ADDR_W-1:0] addr;
    } fetch_req_t;

    typedef struct packed {
        logic valid;
        word_t data;
    } fetch_rsp_t;

    typedef struct packed {
        logic valid;
        block_addr_t addr;
    } l2_req_t;

    typedef struct packed {
        logic valid;
        line_t data;
    } l2_rsp_t;

    typedef struct packed {
        logic hit;
        slot_t way;
        line_t line;
    } lookup_t;

    typedef struct packed {
        logic wr;
        slot_t way;
        block_addr_t addr;
        line_t line;
    } fill_t;

endpackage

`default_nettype wire

// File: hw/icache_way_array.sv
`timescale 1ns/10ps
`default_nettype none

`include "icache_defines.svh"

module icache_way_array
    import icache_pkg::*;
(
    input  wire logic                CLK,
    input  wire logic                rst,
    input  wire logic [index_w-1:0]  index,
    input  wire logic [tag_w-1:0]    tag,
    input  wire fill_t               fill,
    input  wire logic                lru_wr,
    input  wire logic                lru_value,
    output lookup_t                  lookup,
    output logic [1:0]               way_valid,
    output logic                     lru_way,
    // Stored contents of the indexed set, for eviction
    output logic [1:0][tag_w-1:0]    set_tags,
    output line_t [1:0]              set_lines
);

    logic [tag_w-1:0] tag_mem [2][`ICACHE_SETS];
    line_t line_mem [2][`ICACHE_SETS];
    logic [1:0][`ICACHE_SETS-1:0] valid_q;
    logic [`ICACHE_SETS-1:0] lru_q;

    logic [1:0] hit;
    logic [index_w-1:0] fill_index;
    logic [tag_w-1:0] fill_tag;
    logic fill_way;

    //////////////////////////////////////////////////
    // Lookup
    //////////////////////////////////////////////////

    always_comb
    begin
        for (int w = 0; w < 2; w++)
        begin
            set_tags[w] = tag_mem[w][index];
            set_lines[w] = line_mem[w][index];
            way_valid[w] = valid_q[w][index];
            hit[w] = way_valid[w] && (set_tags[w] == tag);
        end
    end

    assign lru_way = lru_q[index];

    always_comb
    begin
        lookup.hit = |hit;
        lookup.way = slot_t'(hit[1]);
        lookup.line = hit[1] ? set_lines[1] : set_lines[0];
    end

    //////////////////////////////////////////////////
    // Fill and LRU update
    //////////////////////////////////////////////////

    assign fill_index = fill.addr[index_w-1:0];
    assign fill_tag = fill.addr[block_addr_w-1:index_w];
    assign fill_way = fill.way[0];

    always_ff @(posedge CLK)
    begin
        if (rst)
        begin
            valid_q <= '0;
            lru_q <= '0;
        end
        else
        begin
            if (fill.wr)
                valid_q[fill_way][fill_index] <= 1'b1;
            if (lru_wr)
                lru_q[index] <= lru_value;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (fill.wr)
        begin
            tag_mem[fill_way][fill_index] <= fill_tag;
            line_mem[fill_way][fill_index] <= fill.line;
        end
    end

    // A block lives in one way only, so the swap and refill paths must agree
    assert property (@(posedge CLK) disable iff (rst) !(&hit))
        else $error("icache_way_array: lookup hit both ways of set %0d", index);

endmodule

`default_nettype wire

// File: hw/icache_victim_buffer.sv
`timescale 1ns/10ps
`default_nettype none

`include "icache_defines.svh"

module icache_victim_buffer
    import icache_pkg::*;
(
    input  wire logic         CLK,
    input  wire logic         rst,
    input  wire block_addr_t  block_addr,
    input  wire fill_t        fill,
    output lookup_t           lookup
);

    localparam int entries = `ICACHE_VICTIM_ENTRIES;
    localparam int ptr_w = $clog2(entries);

    block_addr_t addr_mem [entries];
    line_t line_mem [entries];
    logic [entries-1:0] valid_q;
    logic [ptr_w-1:0] ins_ptr;

    logic insert;
    logic [ptr_w-1:0] wr_slot;

    //////////////////////////////////////////////////
    // Associative match
    //////////////////////////////////////////////////

    always_comb
    begin
        lookup = '0;
        for (int i = 0; i < entries; i++)
        begin
            if (valid_q[i] && (addr_mem[i] == block_addr))
            begin
                lookup.hit = 1'b1;
                lookup.way = slot_t'(i);
                lookup.line = line_mem[i];
            end
        end
    end

    //////////////////////////////////////////////////
    // Insert or in-place swap
    //////////////////////////////////////////////////

    assign insert = (fill.way == slot_t'(entries));
    assign wr_slot = insert ? ins_ptr : fill.way[ptr_w-1:0];

    always_ff @(posedge CLK)
    begin
        if (rst)
        begin
            valid_q <= '0;
            ins_ptr <= '0;
        end
        else if (fill.wr)
        begin
            valid_q[wr_slot] <= 1'b1;
            if (insert)
                ins_ptr <= ins_ptr + 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (fill.wr)
        begin
            addr_mem[wr_slot] <= fill.addr;
            line_mem[wr_slot] <= fill.line;
        end
    end

    // Evicted blocks never duplicate a resident victim
    for (genvar i = 0; i < entries; i++)
    begin : g_uniq
        for (genvar j = i + 1; j < entries; j++)
        begin : g_pair
            assert property (@(posedge CLK) disable iff (rst)
                !(valid_q[i] && valid_q[j] && (addr_mem[i] == addr_mem[j])))
                else $error("icache_victim_buffer: slots %0d and %0d hold one block", i, j);
        end
    end

endmodule

`default_nettype wire

// File: hw/icache_replacement_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "icache_defines.svh"

module icache_replacement_ctrl
    import icache_pkg::*;
(
    input  wire logic         CLK,
    input  wire logic         rst,
    input  wire fetch_req_t   req,
    input  wire lookup_t      way_lookup,
    input  wire lookup_t      victim_lookup,
    input  wire logic [1:0]   way_valid,
    input  wire logic         lru_way,
    input  wire line_t        evict_line,
    input  wire block_addr_t  evict_addr,
    output fill_t             way_fill,
    output fill_t             victim_fill,
    output logic              lru_wr,
    output logic              lru_value,
    output fetch_rsp_t        fetch_rsp,
    output logic              fetch_ready,
    output l2_req_t           l2_req,
    input  wire logic         l2_req_ready,
    input  wire l2_rsp_t      l2_rsp,
    output logic              l2_rsp_ready
);

    typedef enum logic [1:0] {IDLE, REQUEST, WAIT} state_e;

    state_e state_q;
    state_e cur_state;

    logic way_hit;
    logic victim_hit;
    logic miss;
    logic l2_rsp_fire;
    logic refill_way;
    logic refill_evict;
    logic [1:0] word_sel;
    block_addr_t req_block;

    assign req_block = req.addr[`ICACHE_ADDR_W-1:offset_w];
    assign word_sel = req.addr[offset_w-1:2];

    // Way hit wins over victim hit
    assign way_hit = req.valid && way_lookup.hit;
    assign victim_hit = req.valid && !way_lookup.hit && victim_lookup.hit;
    assign miss = req.valid && !way_lookup.hit && !victim_lookup.hit;

    // First invalid way, else LRU
    assign refill_way = !way_valid[0] ? 1'b0 : (!way_valid[1] ? 1'b1 : lru_way);
    assign refill_evict = &way_valid;

    //////////////////////////////////////////////////
    // L2 refill FSM
    //////////////////////////////////////////////////

    // Miss starts the request in the same cycle
    always_comb
    begin
        cur_state = state_q;
        if ((state_q == IDLE) && miss)
            cur_state = REQUEST;
    end

    assign l2_req.valid = (cur_state == REQUEST);
    assign l2_req.addr = req_block;
    assign l2_rsp_ready = (state_q == WAIT);
    assign l2_rsp_fire = l2_rsp_ready && l2_rsp.valid;

    always_ff @(posedge CLK)
    begin
        if (rst)
            state_q <= IDLE;
        else
        begin
            case (cur_state)
                REQUEST:
                    state_q <= l2_req_ready ? WAIT : REQUEST;
                WAIT:
                    state_q <= l2_rsp.valid ? IDLE : WAIT;
                default:
                    state_q <= IDLE;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Write enables and response
    //////////////////////////////////////////////////

    always_comb
    begin
        way_fill = '0;
        victim_fill = '0;
        lru_wr = 1'b0;
        lru_value = 1'b0;
        fetch_rsp = '0;
        if (way_hit)
        begin
            lru_wr = 1'b1;
            lru_value = ~way_lookup.way[0];
            fetch_rsp.valid = 1'b1;
            fetch_rsp.data = way_lookup.line[word_sel];
        end
        else if (victim_hit)
        begin
            // Swap victim line with the LRU way
            way_fill.wr = 1'b1;
            way_fill.way = slot_t'(lru_way);
            way_fill.addr = req_block;
            way_fill.line = victim_lookup.line;
            victim_fill.wr = 1'b1;
            victim_fill.way = victim_lookup.way;
            victim_fill.addr = evict_addr;
            victim_fill.line = evict_line;
            lru_wr = 1'b1;
            lru_value = ~lru_way;
            fetch_rsp.valid = 1'b1;
            fetch_rsp.data = victim_lookup.line[word_sel];
        end
        else if (l2_rsp_fire)
        begin
            way_fill.wr = 1'b1;
            way_fill.way = slot_t'(refill_way);
            way_fill.addr = req_block;
            way_fill.line = l2_rsp.data;
            // Displaced valid line goes to the victim buffer
            victim_fill.wr = refill_evict;
            victim_fill.way = slot_t'(`ICACHE_VICTIM_ENTRIES);
            victim_fill.addr = evict_addr;
            victim_fill.line = evict_line;
            lru_wr = 1'b1;
            lru_value = ~refill_way;
        end
    end

    assign fetch_ready = !req.valid || fetch_rsp.valid;

    assert property (@(posedge CLK) disable iff (rst)
        l2_req.valid && !l2_req_ready |=> l2_req.valid && $stable(l2_req.addr))
        else $error("icache_replacement_ctrl: l2_req changed before ready");

    // Hit answer one cycle after the silent refill edge
    assert property (@(posedge CLK) disable iff (rst)
        l2_rsp_fire |-> !fetch_rsp.valid ##1 fetch_rsp.valid)
        else $error("icache_replacement_ctrl: refill and response out of order");

endmodule

`default_nettype wire

// File: hw/icache_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "icache_defines.svh"

module icache_top
    import icache_pkg::*;
(
    input  wire logic        CLK,
    input  wire logic        rst,
    input  wire fetch_req_t  fetch_req,
    output logic             fetch_ready,
    output fetch_rsp_t       fetch_rsp,
    output l2_req_t          l2_req,
    input  wire logic        l2_req_ready,
    input  wire l2_rsp_t     l2_rsp,
    output logic             l2_rsp_ready
);

    fetch_req_t req_q;
    lookup_t way_lookup;
    lookup_t victim_lookup;
    fill_t way_fill;
    fill_t victim_fill;
    logic [1:0] way_valid;
    logic lru_way;
    logic lru_wr;
    logic lru_value;
    logic [1:0][tag_w-1:0] set_tags;
    line_t [1:0] set_lines;
    logic rep_way;
    line_t evict_line;
    block_addr_t evict_addr;
    logic [index_w-1:0] index;
    logic [tag_w-1:0] tag;

    // Held until answered
    always_ff @(posedge CLK)
    begin
        if (rst)
            req_q <= '0;
        else if (fetch_req.valid && fetch_ready)
            req_q <= fetch_req;
        else if (fetch_rsp.valid)
            req_q.valid <= 1'b0;
    end

    assign index = req_q.addr[offset_w +: index_w];
    assign tag = req_q.addr[`ICACHE_ADDR_W-1 -: tag_w];

    // Eviction candidate matches the refill way choice
    assign rep_way = !way_valid[0] ? 1'b0 : (!way_valid[1] ? 1'b1 : lru_way);
    assign evict_line = set_lines[rep_way];
    assign evict_addr = {set_tags[rep_way], index};

    icache_way_array u_way_array (
        .CLK       (CLK),
        .rst       (rst),
        .index     (index),
        .tag       (tag),
        .fill      (way_fill),
        .lru_wr    (lru_wr),
        .lru_value (lru_value),
        .lookup    (way_lookup),
        .way_valid (way_valid),
        .lru_way   (lru_way),
        .set_tags  (set_tags),
        .set_lines (set_lines)
    );

    icache_victim_buffer u_victim_buffer (
        .CLK        (CLK),
        .rst        (rst),
        .block_addr ({tag, index}),
        .fill       (victim_fill),
        .lookup     (victim_lookup)
    );

    icache_replacement_ctrl u_replacement_ctrl (
        .CLK           (CLK),
        .rst           (rst),
        .req           (req_q),
        .way_lookup    (way_lookup),
        .victim_lookup (victim_lookup),
        .way_valid     (way_valid),
        .lru_way       (lru_way),
        .evict_line    (evict_line),
        .evict_addr    (evict_addr),
        .way_fill      (way_fill),
        .victim_fill   (victim_fill),
        .lru_wr        (lru_wr),
        .lru_value     (lru_value),
        .fetch_rsp     (fetch_rsp),
        .fetch_ready   (fetch_ready),
        .l2_req        (l2_req),
        .l2_req_ready  (l2_req_ready),
        .l2_rsp        (l2_rsp),
        .l2_rsp_ready  (l2_rsp_ready)
    );

endmodule

`default_nettype wire

// File: tests/icache_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "icache_defines.svh"

module icache_tb
    import icache_pkg::*;
();

    localparam int phase_count = 5;
    localparam int cycles_per_phase = 2000;

    logic CLK;
    logic rst;
    fetch_req_t fetch_req;
    logic fetch_ready;
    fetch_rsp_t fetch_rsp;
    l2_req_t l2_req;
    logic l2_req_ready;
    l2_rsp_t l2_rsp;
    logic l2_rsp_ready;

    logic accept;
    logic expect_hit;
    logic held_valid;
    logic [31:0] held_addr;
    int unsigned l2_sent;

    icache_top u_icache_top (
        .CLK          (CLK),
        .rst          (rst),
        .fetch_req    (fetch_req),
        .fetch_ready  (fetch_ready),
        .fetch_rsp    (fetch_rsp),
        .l2_req       (l2_req),
        .l2_req_ready (l2_req_ready),
        .l2_rsp       (l2_rsp),
        .l2_rsp_ready (l2_rsp_ready)
    );

    initial
    begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1, "simulation stopped");
    endtask

    // Memory content rule for every line in L2
    function automatic word_t line_word(input block_addr_t block, input int unsigned idx);
        logic [31:0] seq;
        seq = 32'(block) * 4 + idx;
        return (seq << 2) ^ 32'h5a5a0000;
    endfunction

    function automatic word_t expected_word(input logic [31:0] addr);
        return line_word(addr[31:offset_w], addr[offset_w-1:2]);
    endfunction

    // Returns at the falling edge after acceptance
    task automatic fetch(input logic [31:0] addr, input logic hit);
        while (!fetch_ready)
            @(negedge CLK);
        fetch_req.valid = 1'b1;
        fetch_req.addr = addr;
        expect_hit = hit;
        @(negedge CLK);
        fetch_req.valid = 1'b0;
        expect_hit = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // Request tracking and checks
    //////////////////////////////////////////////////

    assign accept = fetch_req.valid && fetch_ready;

    always_ff @(posedge CLK)
    begin
        if (rst)
        begin
            held_valid <= 1'b0;
            held_addr <= '0;
            l2_sent <= 0;
        end
        else if (accept)
        begin
            held_valid <= 1'b1;
            held_addr <= fetch_req.addr;
            l2_sent <= 0;
        end
        else
        begin
            if (fetch_rsp.valid)
                held_valid <= 1'b0;
            if (l2_req.valid && l2_req_ready)
                l2_sent <= l2_sent + 1;
        end
    end

    assert property (@(posedge CLK)
        rst |=> fetch_ready && !fetch_rsp.valid && !l2_req.valid && !l2_rsp_ready)
        else abort_run($sformatf("error %0t: outputs not idle after reset", $time));

    assert property (@(posedge CLK) disable iff (rst)
        fetch_rsp.valid |-> held_valid && (fetch_rsp.data == expected_word(held_addr)))
        else abort_run($sformatf("error %0t: response %h for address %h, expected %h",
            $time, fetch_rsp.data, held_addr, expected_word(held_addr)));

    // Core stalls while a miss is pending
    assert property (@(posedge CLK) disable iff (rst)
        held_valid && !fetch_rsp.valid |-> !fetch_ready)
        else abort_run($sformatf("error %0t: fetch_ready high during a miss", $time));

    assert property (@(posedge CLK) disable iff (rst)
        l2_req.valid |-> held_valid && (l2_sent == 0)
            && (l2_req.addr == held_addr[31:offset_w]))
        else abort_run($sformatf("error %0t: l2 request %h for held address %h, count %0d",
            $time, l2_req.addr, held_addr, l2_sent));

    assert property (@(posedge CLK) disable iff (rst)
        l2_req.valid && !l2_req_ready |=> l2_req.valid && $stable(l2_req.addr))
        else abort_run($sformatf("error %0t: l2 request dropped or changed before ready",
            $time));

    assert property (@(posedge CLK) disable iff (rst)
        accept && expect_hit |=> fetch_rsp.valid && !l2_req.valid)
        else abort_run($sformatf("error %0t: resident line did not answer next cycle", $time));

    // One pulse per request
    assert property (@(posedge CLK) disable iff (rst)
        fetch_rsp.valid && !accept |=> !fetch_rsp.valid)
        else abort_run($sformatf("error %0t: response longer than one cycle", $time));

    //////////////////////////////////////////////////
    // L2 model
    //////////////////////////////////////////////////

    initial
    begin : l2_model
        block_addr_t blk;
        line_t line;
        l2_req_ready = 1'b0;
        l2_rsp = '0;
        forever
        begin
            @(negedge CLK);
            if (!rst && l2_req.valid)
            begin
                // Back-pressure on the address channel
                repeat ($urandom_range(0, 4)) @(negedge CLK);
                l2_req_ready = 1'b1;
                blk = l2_req.addr;
                @(negedge CLK);
                l2_req_ready = 1'b0;
                repeat ($urandom_range(0, 4)) @(negedge CLK);
                for (int i = 0; i < `ICACHE_WORDS_PER_LINE; i++)
                    line[i] = line_word(blk, i);
                l2_rsp.valid = 1'b1;
                l2_rsp.data = line;
                while (!l2_rsp_ready)
                    @(negedge CLK);
                @(negedge CLK);
                l2_rsp = '0;
            end
        end
    end

    initial
    begin
        repeat (phase_count * cycles_per_phase) @(posedge CLK);
        abort_run($sformatf("watchdog: run did not finish within %0d cycles",
            phase_count * cycles_per_phase));
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial
    begin : stimulus
        logic [31:0] addr;
        void'($urandom(32'hc1b246d4));
        rst = 1'b1;
        fetch_req = '0;
        expect_hit = 1'b0;
        repeat (5) @(negedge CLK);
        rst = 1'b0;
        @(negedge CLK);

        // Cold miss followed by the rest of the line
        fetch(32'h0000_0100, 1'b0);
        fetch(32'h0000_0104, 1'b1);
        fetch(32'h0000_0108, 1'b1);
        fetch(32'h0000_010c, 1'b1);

        // Second line in another set and a back to back re-fetch
        fetch(32'h0000_4528, 1'b0);
        fetch(32'h0000_4520, 1'b1);
        fetch(32'h0000_0100, 1'b1);

        // Three blocks in set 3 with the first two returning from the victim buffer
        fetch(32'h0000_1034, 1'b0);
        fetch(32'h0000_2038, 1'b0);
        fetch(32'h0000_303c, 1'b0);
        fetch(32'h0000_1030, 1'b1);
        fetch(32'h0000_2034, 1'b1);

        // Random mix over six tags in sets 5 and 6
        for (int n = 0; n < 150; n++)
        begin
            addr = ($urandom_range(1, 6) << 8) | ((5 + $urandom_range(0, 1)) << 4)
                | ($urandom_range(0, 3) << 2);
            fetch(addr, 1'b0);
            if ($urandom_range(0, 3) == 0)
                @(negedge CLK);
        end

        while (held_valid)
            @(negedge CLK);
        repeat (3) @(negedge CLK);
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+hw
hw/icache_pkg.sv
hw/icache_way_array.sv
hw/icache_victim_buffer.sv
hw/icache_replacement_ctrl.sv
hw/icache_top.sv
tests/icache_tb.sv

// File: Makefile
# Verilator simulation of the instruction cache testbench

VERILATOR ?= verilator
TOP       ?= icache_tb
FLAGS     ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f build.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
